// File: include/tile_macros.svh
// Bus widths, memory sizes and address map constants of the compute tile
// UART register word offsets and the boot image opcode

`ifndef TILE_MACROS_SVH
`define TILE_MACROS_SVH

// System bus
`define TILE_AW   32
`define TILE_DW   32
`define TILE_SELW 4

// Memory sizes in words
`define DMEM_WORDS 1024
`define BOOT_WORDS 16

// Boot image
`define BOOT_NOP_OP 32'h1500_0000

// Address map
`define REGION_BOOT  4'hf
`define UART_BASE_HI 28'h900_0000

// UART register word offsets
`define UART_REG_TX     2'd0
`define UART_REG_RX     2'd1
`define UART_REG_STATUS 2'd2
`define UART_REG_CTRL   2'd3

`endif

// File: design/tile_bus_pkg.sv
// Bus address union with raw and region views
// Slave select encoding of the address decoder

`default_nettype none

`include "tile_macros.svh"

package tile_bus_pkg;

   // Region view of a bus address
   typedef struct packed {
      logic [3:0]            region;   // Top nibble
      logic [`TILE_AW-5:0]   offset;   // Offset inside the region
   } bus_region_t;

   // Same word, decoded by region in the bus control and as raw
   // byte address in the slaves
   typedef union packed {
      logic [`TILE_AW-1:0] raw;
      bus_region_t         map;
   } bus_addr_u;

   typedef enum logic [1:0] {
      SEL_DM,
      SEL_BOOT,
      SEL_UART,
      SEL_NONE   // Unmapped, answered with err
   } slave_sel_e;

endpackage

`default_nettype wire

// File: design/tile_uart_pkg.sv
// UART register index encoding
// Status and control register bit positions

`default_nettype none

`include "tile_macros.svh"

package tile_uart_pkg;

   typedef enum logic [1:0] {
      UART_TX     = `UART_REG_TX,
      UART_RX     = `UART_REG_RX,
      UART_STATUS = `UART_REG_STATUS,
      UART_CTRL   = `UART_REG_CTRL
   } uart_reg_e;

   // STATUS bits
   localparam int UART_ST_RXFULL  = 0;
   localparam int UART_ST_OVERRUN = 1;

   // CTRL bits
   localparam int UART_CTRL_IRQEN = 0;

endpackage

`default_nettype wire

// File: design/wb_if.sv
// Wishbone classic slave port between bus control and one slave

`default_nettype none

`include "tile_macros.svh"

interface wb_if
   import tile_bus_pkg::*;
();
   bus_addr_u              adr;
   logic [`TILE_DW-1:0]    dat_w;
   logic [`TILE_SELW-1:0]  sel;
   logic                   we;
   logic                   stb;     // cyc already folded in
   logic                   ack;     // Registered, one cycle
   logic [`TILE_DW-1:0]    dat_r;   // Valid with ack

   modport master (
      output adr, dat_w, sel, we, stb,
      input  ack, dat_r
   );

   modport slave (
      input  adr, dat_w, sel, we, stb,
      output ack, dat_r
   );
endinterface

`default_nettype wire

// File: design/tile_bus_ctrl.sv
// Address decode, strobe steering and response multiplex of the tile bus
// Unmapped accesses get a registered error pulse

`default_nettype none

`include "tile_macros.svh"

module tile_bus_ctrl
   import tile_bus_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  cyc_i,
   input  logic                  stb_i,
   input  logic                  we_i,
   input  logic [`TILE_AW-1:0]   adr_i,
   input  logic [`TILE_DW-1:0]   dat_i,
   input  logic [`TILE_SELW-1:0] sel_i,
   output logic                  ack_o,
   output logic                  err_o,
   output logic [`TILE_DW-1:0]   dat_o,
   wb_if.master                  dm_bus,
   wb_if.master                  boot_bus,
   wb_if.master                  uart_bus
);
   bus_addr_u  adr;
   slave_sel_e slave_sel;
   logic       req;
   logic       err_q;

   assign adr = adr_i;
   assign req = cyc_i & stb_i;

   always_comb begin
      if (!adr.map.region[3])
         slave_sel = SEL_DM;                  // Lower half of the map
      else if (adr.map.region == `REGION_BOOT)
         slave_sel = SEL_BOOT;
      else if ({adr.map.region, adr.map.offset[27:4]} == `UART_BASE_HI)
         slave_sel = SEL_UART;                // 16-byte window
      else
         slave_sel = SEL_NONE;
   end

   // Request fan-out, strobe only to the selected slave
   assign dm_bus.adr     = adr;
   assign dm_bus.dat_w   = dat_i;
   assign dm_bus.sel     = sel_i;
   assign dm_bus.we      = we_i;
   assign dm_bus.stb     = req & (slave_sel == SEL_DM);
   assign boot_bus.adr   = adr;
   assign boot_bus.dat_w = dat_i;
   assign boot_bus.sel   = sel_i;
   assign boot_bus.we    = we_i;
   assign boot_bus.stb   = req & (slave_sel == SEL_BOOT);
   assign uart_bus.adr   = adr;
   assign uart_bus.dat_w = dat_i;
   assign uart_bus.sel   = sel_i;
   assign uart_bus.we    = we_i;
   assign uart_bus.stb   = req & (slave_sel == SEL_UART);

   // Error responder, same timing as a slave ack
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= req & (slave_sel == SEL_NONE) & ~err_q;
      end
   end

   // Address is held through the response cycle
   always_comb begin
      case (slave_sel)
         SEL_DM:   dat_o = dm_bus.dat_r;
         SEL_BOOT: dat_o = boot_bus.dat_r;
         SEL_UART: dat_o = uart_bus.dat_r;
         default:  dat_o = '0;
      endcase
   end

   assign ack_o = dm_bus.ack | boot_bus.ack | uart_bus.ack;
   assign err_o = err_q;

   // Slave acks and the error pulse are mutually exclusive
   a_ack_err_excl : assert property (@(posedge clk) disable iff (!rst_n_i)
      !(ack_o && err_o));

   // Every response answers a request seen one cycle before
   a_resp_has_req : assert property (@(posedge clk) disable iff (!rst_n_i)
      (ack_o || err_o) |-> $past(cyc_i && stb_i));

endmodule

`default_nettype wire

// File: design/tile_dmem.sv
// Single-port data memory slave with byte-lane writes

`default_nettype none

`include "tile_macros.svh"

module tile_dmem (
   input logic  clk,
   input logic  rst_n_i,
   wb_if.slave  bus
);
   localparam int OFS_W = $clog2(`TILE_SELW);
   localparam int IDX_W = $clog2(`DMEM_WORDS);

   logic [`TILE_DW-1:0] mem [`DMEM_WORDS];
   logic [IDX_W-1:0]    idx;
   logic                acc;
   logic                ack_q;
   logic [`TILE_DW-1:0] dat_q;

   assign idx = bus.adr.raw[OFS_W +: IDX_W];   // Wraps inside the depth
   assign acc = bus.stb & ~ack_q;              // Skip the held ack cycle

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= acc;
      end
   end

   always_ff @(posedge clk) begin
      if (acc) begin
         if (bus.we) begin
            for (int i = 0; i < `TILE_SELW; i++) begin
               if (bus.sel[i]) begin
                  mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
               end
            end
         end
         dat_q <= mem[idx];   // Old word on a write
      end
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = dat_q;

   a_ack_single : assert property (@(posedge clk) disable iff (!rst_n_i)
      bus.ack |=> !bus.ack);

endmodule

`default_nettype wire

// File: design/tile_bootrom.sv
// Read-only boot image slave, one no-op opcode per word

`default_nettype none

`include "tile_macros.svh"

module tile_bootrom
   import tile_bus_pkg::*;
(
   input logic  clk,
   input logic  rst_n_i,
   wb_if.slave  bus
);
   localparam int OFS_W = $clog2(`TILE_SELW);
   localparam int IDX_W = $clog2(`BOOT_WORDS);

   bus_addr_u           adr;
   logic [IDX_W-1:0]    idx;
   logic                acc;
   logic                ack_q;
   logic [`TILE_DW-1:0] dat_q;

   assign adr = bus.adr;
   assign idx = adr.raw[OFS_W +: IDX_W];   // Image repeats over the region
   assign acc = bus.stb & ~ack_q;

   // Writes are acknowledged like reads and change nothing
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= acc;
      end
   end

   always_ff @(posedge clk) begin
      if (acc) begin
         dat_q <= `BOOT_NOP_OP | {{(`TILE_DW-IDX_W){1'b0}}, idx};   // Word index in low bits
      end
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = dat_q;

endmodule

`default_nettype wire

// File: design/tile_uart_regs.sv
// Debug UART register block: TX strobe, one-character RX buffer
// Status flags and interrupt enable

`default_nettype none

`include "tile_macros.svh"

module tile_uart_regs
   import tile_uart_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n_i,
   wb_if.slave        bus,
   output logic       tx_valid_o,
   output logic [7:0] tx_data_o,
   input  logic       rx_valid_i,
   input  logic [7:0] rx_data_i,
   output logic       irq_o
);
   localparam int OFS_W = $clog2(`TILE_SELW);

   uart_reg_e           reg_idx;
   logic                acc;
   logic                wr_tx;
   logic                wr_ctrl;
   logic                rd_rx;
   logic                rd_status;
   logic                buf_free;
   logic                ack_q;
   logic                rxfull_q;
   logic                overrun_q;
   logic                irqen_q;
   logic [7:0]          rx_data_q;
   logic [`TILE_DW-1:0] rd_word;
   logic [`TILE_DW-1:0] dat_q;

   assign reg_idx   = uart_reg_e'(bus.adr.raw[OFS_W +: $bits(uart_reg_e)]);
   assign acc       = bus.stb & ~ack_q;
   assign wr_tx     = acc & bus.we & (reg_idx == UART_TX);
   assign wr_ctrl   = acc & bus.we & (reg_idx == UART_CTRL);
   assign rd_rx     = acc & ~bus.we & (reg_idx == UART_RX);
   assign rd_status = acc & ~bus.we & (reg_idx == UART_STATUS);
   assign buf_free  = ~rxfull_q | rd_rx;   // Emptied by this read

   always_comb begin
      rd_word = '0;
      case (reg_idx)
         UART_RX:     rd_word[7:0] = rx_data_q;
         UART_STATUS: begin
            rd_word[UART_ST_RXFULL]  = rxfull_q;
            rd_word[UART_ST_OVERRUN] = overrun_q;
         end
         UART_CTRL:   rd_word[UART_CTRL_IRQEN] = irqen_q;
         default:     rd_word = '0;   // TX reads back zero
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_q      <= 1'b0;
         tx_valid_o <= 1'b0;
         rxfull_q   <= 1'b0;
         overrun_q  <= 1'b0;
         irqen_q    <= 1'b0;
      end else begin
         ack_q      <= acc;
         tx_valid_o <= wr_tx;   // Pulses together with the ack
         if (wr_ctrl) begin
            irqen_q <= bus.dat_w[UART_CTRL_IRQEN];
         end
         if (rx_valid_i && buf_free) begin
            rxfull_q <= 1'b1;
         end else if (rd_rx) begin
            rxfull_q <= 1'b0;
         end
         if (rx_valid_i && !buf_free) begin
            overrun_q <= 1'b1;   // Character dropped
         end else if (rd_status) begin
            overrun_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_valid_i && buf_free) begin
         rx_data_q <= rx_data_i;
      end
      if (wr_tx) begin
         tx_data_o <= bus.dat_w[7:0];   // Byte lane 0
      end
      if (acc) begin
         dat_q <= rd_word;
      end
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = dat_q;
   assign irq_o     = rxfull_q & irqen_q;

   a_tx_pulse : assert property (@(posedge clk) disable iff (!rst_n_i)
      tx_valid_o |=> !tx_valid_o);

endmodule

`default_nettype wire

// File: design/compute_tile.sv
// Compute tile top level: bus control, data memory, boot ROM
// and debug UART registers on the tile system bus

`default_nettype none

`include "tile_macros.svh"

module compute_tile (
   input  logic                  clk,
   input  logic                  rst_n_i,

   // Bus master, data port
   input  logic                  cyc_i,
   input  logic                  stb_i,
   input  logic                  we_i,
   input  logic [`TILE_AW-1:0]   adr_i,
   input  logic [`TILE_DW-1:0]   dat_i,
   input  logic [`TILE_SELW-1:0] sel_i,
   output logic                  ack_o,
   output logic                  err_o,
   output logic [`TILE_DW-1:0]   dat_o,

   // UART character side
   output logic                  tx_valid_o,
   output logic [7:0]            tx_data_o,
   input  logic                  rx_valid_i,
   input  logic [7:0]            rx_data_i,
   output logic                  uart_irq_o
);
   wb_if dm_bus ();
   wb_if boot_bus ();
   wb_if uart_bus ();

   tile_bus_ctrl u_bus_ctrl (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .cyc_i    (cyc_i),
      .stb_i    (stb_i),
      .we_i     (we_i),
      .adr_i    (adr_i),
      .dat_i    (dat_i),
      .sel_i    (sel_i),
      .ack_o    (ack_o),
      .err_o    (err_o),
      .dat_o    (dat_o),
      .dm_bus   (dm_bus),
      .boot_bus (boot_bus),
      .uart_bus (uart_bus)
   );

   tile_dmem u_dmem (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus     (dm_bus)
   );

   tile_bootrom u_bootrom (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus     (boot_bus)
   );

   tile_uart_regs u_uart (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .bus        (uart_bus),
      .tx_valid_o (tx_valid_o),
      .tx_data_o  (tx_data_o),
      .rx_valid_i (rx_valid_i),
      .rx_data_i  (rx_data_i),
      .irq_o      (uart_irq_o)
   );

endmodule

`default_nettype wire

// File: sim/tb_compute_tile.sv
// Testbench of the compute tile: clock, reset, bus and UART stimulus
// Reference model of data memory, boot image and UART registers, with checks

`default_nettype none

`include "tile_macros.svh"

module tb_compute_tile
   import tile_uart_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RESP_TIMEOUT  = 20;
   localparam int DRAIN_TIMEOUT = 20;

   // One completed bus access, handed to the checker
   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] exp_dat;
      logic [31:0] got_dat;
      logic [7:0]  lat;
      logic        exp_err;
      logic        got_ack;
      logic        got_err;
      logic        linger;
      logic        chk_dat;
   } acc_rec_t;

   logic        clk;
   logic        rst_n_i;
   logic        cyc_i;
   logic        stb_i;
   logic        we_i;
   logic [31:0] adr_i;
   logic [31:0] dat_i;
   logic [3:0]  sel_i;
   logic        ack_o;
   logic        err_o;
   logic [31:0] dat_o;
   logic        tx_valid_o;
   logic [7:0]  tx_data_o;
   logic        rx_valid_i;
   logic [7:0]  rx_data_i;
   logic        uart_irq_o;

   acc_rec_t    rec_q [$];
   int          checks = 0;
   int          errors = 0;
   int          tx_count = 0;
   logic [7:0]  tx_last = 8'd0;
   logic [31:0] lfsr = 32'h74cf_0710;

   // Reference model state
   logic [31:0] dm_shadow [`DMEM_WORDS];
   logic        ref_rxfull = 1'b0;
   logic        ref_overrun = 1'b0;
   logic        ref_irqen = 1'b0;
   logic [7:0]  ref_rxdata = 8'd0;

   compute_tile i_compute_tile (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .cyc_i      (cyc_i),
      .stb_i      (stb_i),
      .we_i       (we_i),
      .adr_i      (adr_i),
      .dat_i      (dat_i),
      .sel_i      (sel_i),
      .ack_o      (ack_o),
      .err_o      (err_o),
      .dat_o      (dat_o),
      .tx_valid_o (tx_valid_o),
      .tx_data_o  (tx_data_o),
      .rx_valid_i (rx_valid_i),
      .rx_data_i  (rx_data_i),
      .uart_irq_o (uart_irq_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      end
      return r;
   endfunction

   function automatic logic mapped(input logic [31:0] adr);
      return !adr[31] || (adr[31:28] == `REGION_BOOT) || (adr[31:4] == `UART_BASE_HI);
   endfunction

   // Random alias of a data memory word
   function automatic logic [31:0] dm_addr(input logic [9:0] idx);
      logic [31:0] hi;
      hi = rand_bits(19);
      return {1'b0, hi[18:0], idx, 2'b00};
   endfunction

   function automatic logic [31:0] uart_addr(input logic [1:0] r);
      return {`UART_BASE_HI, r, 2'b00};
   endfunction

   // Expected read word of one access; updates the model state
   function automatic logic [31:0] ref_access(input logic we, input logic [31:0] adr,
                                              input logic [31:0] dat, input logic [3:0] sel);
      logic [31:0] word;
      int          idx;
      word = '0;
      if (!adr[31]) begin
         idx  = int'(adr[30:2]) % `DMEM_WORDS;
         word = dm_shadow[idx];
         for (int b = 0; b < 4; b++) begin
            if (we && sel[b])
               dm_shadow[idx][8*b +: 8] = dat[8*b +: 8];
         end
      end else if (adr[31:28] == `REGION_BOOT) begin
         word = `BOOT_NOP_OP | 32'(int'(adr[27:2]) % `BOOT_WORDS);   // Writes ignored
      end else if (adr[31:4] == `UART_BASE_HI) begin
         case (adr[3:2])
            `UART_REG_RX: begin
               if (!we) begin
                  word       = {24'd0, ref_rxdata};
                  ref_rxfull = 1'b0;
               end
            end
            `UART_REG_STATUS: begin
               if (!we) begin
                  word[UART_ST_RXFULL]  = ref_rxfull;
                  word[UART_ST_OVERRUN] = ref_overrun;
                  ref_overrun           = 1'b0;
               end
            end
            `UART_REG_CTRL: begin
               if (we)
                  ref_irqen = dat[UART_CTRL_IRQEN];
               else
                  word[UART_CTRL_IRQEN] = ref_irqen;
            end
            default: word = '0;   // TX reads zero
         endcase
      end
      return word;
   endfunction

   function automatic void ref_rx(input logic [7:0] ch);
      if (!ref_rxfull) begin
         ref_rxfull = 1'b1;
         ref_rxdata = ch;
      end else begin
         ref_overrun = 1'b1;   // Second character lost
      end
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR @%0t: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   // One Wishbone classic cycle, started and ended on a falling edge
   task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
      acc_rec_t rec;
      int       n;
      logic     done;
      rec         = '0;
      rec.adr     = adr;
      rec.exp_err = !mapped(adr);
      rec.chk_dat = !we && !rec.exp_err;
      rec.exp_dat = ref_access(we, adr, dat, sel);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = we;
      adr_i = adr;
      dat_i = dat;
      sel_i = sel;
      n     = 0;
      done  = 1'b0;
      while (!done && n < RESP_TIMEOUT) begin
         @(negedge clk);
         n++;
         done = ack_o | err_o;
      end
      rec.got_ack = ack_o;
      rec.got_err = err_o;
      rec.got_dat = dat_o;
      rec.lat     = 8'(n);
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      @(negedge clk);
      rec.linger = ack_o | err_o;   // Response must be gone by now
      if (done) begin
         rec_q.push_back(rec);
      end else begin
         errors++;
         $display("Bus access to %h got no ack or err within %0d cycles", adr, RESP_TIMEOUT);
      end
   endtask

   task automatic rx_char(input logic [7:0] ch);
      rx_valid_i = 1'b1;
      rx_data_i  = ch;
      ref_rx(ch);
      @(negedge clk);
      rx_valid_i = 1'b0;
   endtask

   // Checker of completed accesses
   always @(posedge clk) begin
      acc_rec_t r;
      while (rec_q.size() > 0) begin
         r = rec_q.pop_front();
         check_value($sformatf("ack for %h", r.adr), 32'(r.got_ack), 32'(!r.exp_err));
         check_value($sformatf("err for %h", r.adr), 32'(r.got_err), 32'(r.exp_err));
         // Seen on the first falling edge after the sampling edge
         check_value($sformatf("latency for %h", r.adr), 32'(r.lat), 32'd1);
         check_value($sformatf("single response for %h", r.adr), 32'(r.linger), 32'd0);
         if (r.chk_dat)
            check_value($sformatf("read data at %h", r.adr), r.got_dat, r.exp_dat);
      end
   end

   always @(posedge clk) begin
      if (tx_valid_o === 1'b1) begin
         tx_count++;
         tx_last = tx_data_o;
      end
   end

   initial begin
      int          i;
      int          n;
      int          tx_before;
      logic [31:0] wd;
      logic [31:0] hi;
      logic [9:0]  dm_idx [8];
      logic [31:0] bad_adr [3];
      bad_adr[0] = 32'h9000_0010;
      bad_adr[1] = 32'ha000_0000;
      bad_adr[2] = 32'he000_0000;
      rst_n_i    = 1'b0;
      cyc_i      = 1'b0;
      stb_i      = 1'b0;
      we_i       = 1'b0;
      adr_i      = '0;
      dat_i      = '0;
      sel_i      = '0;
      rx_valid_i = 1'b0;
      rx_data_i  = '0;
      repeat (2) @(negedge clk);
      rst_n_i = 1'b1;
      check_value("ack_o after reset", 32'(ack_o), 32'd0);
      check_value("err_o after reset", 32'(err_o), 32'd0);
      check_value("tx_valid_o after reset", 32'(tx_valid_o), 32'd0);
      check_value("uart_irq_o after reset", 32'(uart_irq_o), 32'd0);

      // Data memory through aliased addresses
      for (i = 0; i < 8; i++) begin
         dm_idx[i] = 10'(rand_bits(10));
         bus_access(1'b1, dm_addr(dm_idx[i]), rand_bits(32), 4'hf);
      end
      for (i = 0; i < 16; i++) begin
         wd = rand_bits(3);
         bus_access(1'b1, dm_addr(dm_idx[wd[2:0]]), rand_bits(32), 4'(rand_bits(4)));
      end
      for (i = 0; i < 8; i++)
         bus_access(1'b0, dm_addr(dm_idx[i]), 32'd0, 4'hf);

      // Boot ROM reads, then a write that must not stick
      for (i = 0; i < 6; i++) begin
         hi = rand_bits(26);
         bus_access(1'b0, {`REGION_BOOT, hi[25:0], 2'b00}, 32'd0, 4'hf);
      end
      bus_access(1'b1, {`REGION_BOOT, hi[25:0], 2'b00}, rand_bits(32), 4'hf);
      bus_access(1'b0, {`REGION_BOOT, hi[25:0], 2'b00}, 32'd0, 4'hf);

      for (i = 0; i < 3; i++) begin
         bus_access(1'b0, bad_adr[i], 32'd0, 4'hf);
         bus_access(1'b1, bad_adr[i], rand_bits(32), 4'hf);
      end

      tx_before = tx_count;
      wd = rand_bits(32);
      bus_access(1'b1, uart_addr(`UART_REG_TX), wd, 4'hf);
      check_value("tx pulse count", 32'(tx_count - tx_before), 32'd1);
      check_value("tx character", {24'd0, tx_last}, {24'd0, wd[7:0]});

      // Receive buffer and overrun
      rx_char(8'h41);
      bus_access(1'b0, uart_addr(`UART_REG_STATUS), 32'd0, 4'hf);
      bus_access(1'b0, uart_addr(`UART_REG_RX), 32'd0, 4'hf);
      bus_access(1'b0, uart_addr(`UART_REG_STATUS), 32'd0, 4'hf);
      rx_char(8'h55);
      rx_char(8'h66);
      bus_access(1'b0, uart_addr(`UART_REG_STATUS), 32'd0, 4'hf);
      bus_access(1'b0, uart_addr(`UART_REG_STATUS), 32'd0, 4'hf);
      bus_access(1'b0, uart_addr(`UART_REG_RX), 32'd0, 4'hf);
      bus_access(1'b0, uart_addr(`UART_REG_STATUS), 32'd0, 4'hf);

      // Interrupt gating by IRQEN
      rx_char(8'h3c);
      check_value("irq with IRQEN clear", 32'(uart_irq_o), 32'd0);
      bus_access(1'b0, uart_addr(`UART_REG_RX), 32'd0, 4'hf);
      bus_access(1'b1, uart_addr(`UART_REG_CTRL), 32'd1, 4'hf);
      bus_access(1'b0, uart_addr(`UART_REG_CTRL), 32'd0, 4'hf);
      check_value("irq with empty buffer", 32'(uart_irq_o), 32'd0);
      rx_char(8'h7e);
      check_value("irq with character", 32'(uart_irq_o), 32'd1);
      bus_access(1'b0, uart_addr(`UART_REG_RX), 32'd0, 4'hf);
      check_value("irq after RX read", 32'(uart_irq_o), 32'd0);

      n = 0;
      while (rec_q.size() > 0 && n < DRAIN_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (rec_q.size() > 0) begin
         errors++;
         $display("Checker did not consume all bus responses before the end of the test");
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
design/tile_bus_pkg.sv
design/tile_uart_pkg.sv
design/wb_if.sv
design/tile_bus_ctrl.sv
design/tile_dmem.sv
design/tile_bootrom.sv
design/tile_uart_regs.sv
design/compute_tile.sv
sim/tb_compute_tile.sv

// File: Makefile
# Verilator build and run of the compute tile testbench

VERILATOR ?= verilator
TOP       ?= tb_compute_tile
RTL_TOP   ?= compute_tile
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing

RTL_SRCS ?= design/tile_bus_pkg.sv design/tile_uart_pkg.sv design/wb_if.sv \
            design/tile_bus_ctrl.sv design/tile_dmem.sv design/tile_bootrom.sv \
            design/tile_uart_regs.sv design/compute_tile.sv
SRCS     := $(RTL_SRCS) sim/tb_compute_tile.sv include/tile_macros.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+include --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
